// File: gp_mem_pkg.sv
// Memory-side types and beat geometry: address, read beat, pixel word
`default_nettype none

package gp_mem_pkg;

   // ------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------

   // Word address into external memory
   typedef logic [30:0]  mem_addr_t;

   // One read beat from the memory controller
   typedef logic [127:0] mem_beat_t;

   // One pixel word handed to the display side
   typedef logic [31:0]  pix_word_t;

   // ------------------------------------------------------------
   // Beat layout
   // ------------------------------------------------------------

   // Lowest 32 bits of a beat hold the earliest word
   localparam int WORDS_PER_BEAT = 4;

   // Two beats per request fill one buffer half of eight words
   localparam int BEATS_PER_REQ = 2;

endpackage

`default_nettype wire

// File: gp_frame_pkg.sv
// Frame geometry: coordinate type, frame select field, x step per request
`default_nettype none

package gp_frame_pkg;

   // ------------------------------------------------------------
   // Coordinates
   // ------------------------------------------------------------

   // x or y position within the frame
   typedef logic [9:0] coord_t;

   // Pixels covered by one request
   localparam int X_STEP = 8;

   // ------------------------------------------------------------
   // Start code fields
   // ------------------------------------------------------------

   // Frame select lives in bits 27..22 of the start code
   localparam int FSEL_W   = 6;
   localparam int FSEL_LSB = 22;

   // Address layout from high bit to low
   //   6 zero bits, frame select, y, x/8 (7 bits), 2 zero bits

endpackage

`default_nettype wire

// File: sync_fifo.sv
// Single-clock FIFO with a type parameter for its payload
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
   parameter type T     = logic [31:0],
   parameter int  DEPTH = 4
) (
   input  wire  clk,
   input  wire  rst,
   input  wire  wr_en,
   input  wire  T wr_data,
   output logic full,
   input  wire  rd_en,
   output T     rd_data,
   output logic valid
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic push;
   logic pop;

   assign full    = (count == CNT_W'(DEPTH));
   assign valid   = (count != '0);
   assign rd_data = mem[rd_ptr];

   assign push = wr_en && !full;
   assign pop  = rd_en && valid;

   // Payload storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // ------------------------------------------------------------
   // Pointers and occupancy
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves count unchanged
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: pixel_prefetch.sv
// Prefetch engine: request FSM, address generator, ping-pong pixel buffer, read pointer, discard
`timescale 1ns/100ps
`default_nettype none

module pixel_prefetch #(
   parameter int LINE_WIDTH = 800
) (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    start,
   input  wire [31:0]             start_code,
   input  wire                    abort,
   output logic                   af_wr_en,
   output gp_mem_pkg::mem_addr_t  af_addr,
   input  wire                    af_full,
   input  wire                    rdf_valid,
   input  wire gp_mem_pkg::mem_beat_t rdf_beat,
   output logic                   rdf_rd_en,
   output gp_mem_pkg::pix_word_t  pix_data,
   output logic                   pix_stall,
   input  wire                    pix_hold
);

   localparam int WPB       = gp_mem_pkg::WORDS_PER_BEAT;
   localparam int BPR       = gp_mem_pkg::BEATS_PER_REQ;
   localparam int PIX_W     = $bits(gp_mem_pkg::pix_word_t);
   localparam int BUF_WORDS = 2 * BPR * WPB;
   localparam int CNT_W     = 8;

   localparam gp_frame_pkg::coord_t X_LAST =
      gp_frame_pkg::coord_t'(LINE_WIDTH - gp_frame_pkg::X_STEP);

   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      REQ_A   = 3'd1,
      BEATS_A = 3'd2,
      REQ_B   = 3'd3,
      BEATS_B = 3'd4
   } state_t;

   state_t state;

   logic [gp_frame_pkg::FSEL_W-1:0] fsel;
   gp_frame_pkg::coord_t            x;
   gp_frame_pkg::coord_t            y;

   gp_mem_pkg::pix_word_t pix_buf [BUF_WORDS];

   // rd_ptr is the last consumed slot, nxt_ptr the word on offer
   logic [3:0] rd_ptr;
   logic [3:0] nxt_ptr;
   logic [1:0] written;
   logic       beat_idx;
   logic       fill_half;

   logic [CNT_W-1:0] owed;
   logic [CNT_W-1:0] owed_next;
   logic [CNT_W-1:0] drop;

   logic consume;
   logic req_ok;
   logic beat_take;

   // ------------------------------------------------------------
   // Request side
   // ------------------------------------------------------------

   // Only refill a half once the reader has moved out of it
   assign req_ok = ((state == REQ_A) &&  rd_ptr[3]) ||
                   ((state == REQ_B) && !rd_ptr[3]);

   // Start and abort take priority over any push
   assign af_wr_en = req_ok && !af_full && !start && !abort;
   assign af_addr  = {6'b0, fsel, y, x[9:3], 2'b00};

   // ------------------------------------------------------------
   // Beat intake and stale-beat discard
   // ------------------------------------------------------------
   assign rdf_rd_en = rdf_valid;
   assign fill_half = (state == BEATS_B);
   assign beat_take = rdf_valid && (drop == '0) &&
                      ((state == BEATS_A) || (state == BEATS_B));

   always_comb begin
      owed_next = owed;
      if (af_wr_en) begin
         owed_next = owed_next + CNT_W'(BPR);
      end
      if (rdf_valid) begin
         owed_next = owed_next - 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Read side
   // ------------------------------------------------------------
   assign nxt_ptr   = rd_ptr + 1'b1;
   assign pix_data  = pix_buf[nxt_ptr];
   assign pix_stall = !written[nxt_ptr[3]];
   assign consume   = !pix_stall && !pix_hold;

   // Buffer payload
   always_ff @(posedge clk) begin
      if (beat_take) begin
         for (int i = 0; i < WPB; i++) begin
            pix_buf[{fill_half, beat_idx, 2'(i)}] <= rdf_beat[i*PIX_W +: PIX_W];
         end
      end
   end

   // ------------------------------------------------------------
   // Control state
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         fsel     <= '0;
         x        <= '0;
         y        <= '0;
         rd_ptr   <= 4'hf;
         written  <= 2'b00;
         beat_idx <= 1'b0;
         owed     <= '0;
         drop     <= '0;
      end else begin
         owed <= owed_next;

         // Whatever is still owed becomes stale on a restart or abort
         if (start || abort) begin
            drop <= owed_next;
         end else if (rdf_valid && (drop != '0)) begin
            drop <= drop - 1'b1;
         end

         if (start) begin
            fsel     <= start_code[gp_frame_pkg::FSEL_LSB +: gp_frame_pkg::FSEL_W];
            x        <= '0;
            y        <= '0;
            state    <= REQ_A;
            rd_ptr   <= 4'hf;
            written  <= 2'b00;
            beat_idx <= 1'b0;
         end else if (abort) begin
            state    <= IDLE;
            rd_ptr   <= 4'hf;
            written  <= 2'b00;
            beat_idx <= 1'b0;
         end else begin
            // Leaving a half frees it for the next fill
            if (consume) begin
               rd_ptr <= nxt_ptr;
               if (nxt_ptr[2:0] == 3'd7) begin
                  written[nxt_ptr[3]] <= 1'b0;
               end
            end

            case (state)
               REQ_A, REQ_B: begin
                  if (af_wr_en) begin
                     if (x == X_LAST) begin
                        x <= '0;
                        y <= y + 1'b1;
                     end else begin
                        x <= x + gp_frame_pkg::coord_t'(gp_frame_pkg::X_STEP);
                     end
                     state <= (state == REQ_A) ? BEATS_A : BEATS_B;
                  end
               end
               BEATS_A, BEATS_B: begin
                  if (beat_take) begin
                     beat_idx <= beat_idx + 1'b1;
                     if (beat_idx == 1'(BPR - 1)) begin
                        written[fill_half] <= 1'b1;
                        state <= (state == BEATS_A) ? REQ_B : REQ_A;
                     end
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: gp_fetch_top.sv
// Pixel fetch top level: address FIFO, read-data FIFO and prefetch engine
`timescale 1ns/100ps
`default_nettype none

module gp_fetch_top #(
   parameter int LINE_WIDTH = 800,
   parameter int AF_DEPTH   = 4,
   parameter int RDF_DEPTH  = 4
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        start,
   input  wire [31:0]                 start_code,
   input  wire                        abort,
   output logic                       mem_addr_valid,
   output gp_mem_pkg::mem_addr_t      mem_addr,
   input  wire                        mem_addr_rd_en,
   input  wire                        mem_data_wr_en,
   input  wire gp_mem_pkg::mem_beat_t mem_data,
   output logic                       mem_data_full,
   output gp_mem_pkg::pix_word_t      pix_data,
   output logic                       pix_stall,
   input  wire                        pix_hold
);

   // Engine to address FIFO
   logic                  af_wr_en;
   gp_mem_pkg::mem_addr_t af_addr;
   logic                  af_full;

   // Read-data FIFO to engine
   logic                  rdf_valid;
   gp_mem_pkg::mem_beat_t rdf_beat;
   logic                  rdf_rd_en;

   // ------------------------------------------------------------
   // Request addresses toward memory
   // ------------------------------------------------------------
   sync_fifo #(
      .T     (gp_mem_pkg::mem_addr_t),
      .DEPTH (AF_DEPTH)
   ) addr_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (af_wr_en),
      .wr_data (af_addr),
      .full    (af_full),
      .rd_en   (mem_addr_rd_en),
      .rd_data (mem_addr),
      .valid   (mem_addr_valid)
   );

   // ------------------------------------------------------------
   // Read beats from memory
   // ------------------------------------------------------------
   sync_fifo #(
      .T     (gp_mem_pkg::mem_beat_t),
      .DEPTH (RDF_DEPTH)
   ) data_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (mem_data_wr_en),
      .wr_data (mem_data),
      .full    (mem_data_full),
      .rd_en   (rdf_rd_en),
      .rd_data (rdf_beat),
      .valid   (rdf_valid)
   );

   pixel_prefetch #(
      .LINE_WIDTH (LINE_WIDTH)
   ) prefetch (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .start_code (start_code),
      .abort      (abort),
      .af_wr_en   (af_wr_en),
      .af_addr    (af_addr),
      .af_full    (af_full),
      .rdf_valid  (rdf_valid),
      .rdf_beat   (rdf_beat),
      .rdf_rd_en  (rdf_rd_en),
      .pix_data   (pix_data),
      .pix_stall  (pix_stall),
      .pix_hold   (pix_hold)
   );

endmodule

`default_nettype wire

// File: tb_gp_fetch.sv
// Testbench for the pixel fetch top: clock, reset, LFSR, memory model, scoreboard, tests, timeout
`timescale 1ns/100ps
`default_nettype none

module tb_gp_fetch;

   localparam int LINE_WIDTH    = 800;
   localparam int REQS_PER_LINE = LINE_WIDTH / 8;
   localparam int MAX_DELAY     = 15;
   localparam int REQS_SEQ      = 110;
   localparam int REQS_BP       = 120;
   localparam int REQS_RESTART  = 80;
   localparam int REQS_ABORT    = 16;
   localparam int REQ_BUDGET    = 4 * (MAX_DELAY + 1);
   localparam int CYCLE_LIMIT   =
      (REQS_SEQ + REQS_BP + REQS_RESTART + REQS_ABORT) * REQ_BUDGET + 1000;

   logic                  clk            = 1'b0;
   logic                  rst            = 1'b1;
   logic                  start          = 1'b0;
   logic [31:0]           start_code     = '0;
   logic                  abort          = 1'b0;
   logic                  mem_addr_rd_en = 1'b0;
   logic                  mem_data_wr_en = 1'b0;
   gp_mem_pkg::mem_beat_t mem_data       = '0;
   logic                  pix_hold       = 1'b0;
   logic                  mem_addr_valid;
   gp_mem_pkg::mem_addr_t mem_addr;
   logic                  mem_data_full;
   gp_mem_pkg::pix_word_t pix_data;
   logic                  pix_stall;

   // Memory model state
   logic                  rand_on  = 1'b0;
   logic                  pop_en   = 1'b1;
   logic [31:0]           lfsr     = 32'h1332_b276;
   int                    cycle    = 0;
   gp_mem_pkg::mem_addr_t pend_addr [$];
   int                    pend_due  [$];
   logic                  beat_sel = 1'b0;

   // Scoreboard state
   logic                  active     = 1'b0;
   logic                  started    = 1'b0;
   logic [5:0]            cur_fsel   = '0;
   logic [63:0]           stale_fsel = '0;
   int                    exp_n      = 0;
   int                    pix_idx    = 0;
   int                    late_room  = 0;
   int                    errors     = 0;
   int                    n_pass     = 0;
   int                    n_fail     = 0;
   int                    mark       = 0;
   gp_mem_pkg::mem_addr_t popped;
   gp_mem_pkg::pix_word_t exp_word;

   always #2 clk = ~clk;

   gp_fetch_top #(
      .LINE_WIDTH (LINE_WIDTH),
      .AF_DEPTH   (4),
      .RDF_DEPTH  (4)
   ) uut (
      .clk            (clk),
      .rst            (rst),
      .start          (start),
      .start_code     (start_code),
      .abort          (abort),
      .mem_addr_valid (mem_addr_valid),
      .mem_addr       (mem_addr),
      .mem_addr_rd_en (mem_addr_rd_en),
      .mem_data_wr_en (mem_data_wr_en),
      .mem_data       (mem_data),
      .mem_data_full  (mem_data_full),
      .pix_data       (pix_data),
      .pix_stall      (pix_stall),
      .pix_hold       (pix_hold)
   );

   // ------------------------------------------------------------
   // Reference model helpers
   // ------------------------------------------------------------

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Address of request n within a frame
   function automatic gp_mem_pkg::mem_addr_t addr_of(input logic [5:0] fs, input int n);
      gp_mem_pkg::mem_addr_t a;
      a        = '0;
      a[24:19] = fs;
      a[18:9]  = 10'(n / REQS_PER_LINE);
      a[8:2]   = 7'(n % REQS_PER_LINE);
      return a;
   endfunction

   // Memory contents unique per address and word index
   function automatic gp_mem_pkg::pix_word_t word_of(input gp_mem_pkg::mem_addr_t a,
                                                     input logic [2:0] w);
      return {a[24:2], 6'h2d, w};
   endfunction

   function automatic gp_mem_pkg::mem_beat_t beat_of(input gp_mem_pkg::mem_addr_t a,
                                                     input logic b);
      gp_mem_pkg::mem_beat_t beat;
      for (int i = 0; i < 4; i++) begin
         beat[i*32 +: 32] = word_of(a, {b, 2'(i)});
      end
      return beat;
   endfunction

   task automatic flag_mismatch(input string msg);
      $display("FAILED %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic note_problem(input string msg);
      $display("problem at %0t: %s", $time, msg);
      errors++;
   endtask

   // ------------------------------------------------------------
   // Memory model and consumer
   // ------------------------------------------------------------
   always @(posedge clk) begin
      if (rst) begin
         mem_addr_rd_en <= 1'b0;
         mem_data_wr_en <= 1'b0;
         pix_hold       <= 1'b0;
         pend_addr.delete();
         pend_due.delete();
         beat_sel = 1'b0;
      end else begin
         if (mem_addr_valid && mem_addr_rd_en) begin
            pend_addr.push_back(mem_addr);
            pend_due.push_back(cycle + (rand_on ? int'(rand_bits(4)) : 0));
         end
         // Pop at most every other cycle so valid is known to hold
         if (pop_en && mem_addr_valid && !mem_addr_rd_en) begin
            mem_addr_rd_en <= rand_on ? (rand_bits(1) != 0) : 1'b1;
         end else begin
            mem_addr_rd_en <= 1'b0;
         end
         // Two beats per address with the oldest address first
         if (!mem_data_wr_en && !mem_data_full && pend_addr.size() != 0 &&
             cycle >= pend_due[0]) begin
            mem_data_wr_en <= 1'b1;
            mem_data       <= beat_of(pend_addr[0], beat_sel);
            if (beat_sel) begin
               void'(pend_addr.pop_front());
               void'(pend_due.pop_front());
            end
            beat_sel = !beat_sel;
         end else begin
            mem_data_wr_en <= 1'b0;
         end
         if (rand_on) begin
            pix_hold <= (rand_bits(1) != 0);
         end else begin
            pix_hold <= 1'b0;
         end
      end
   end

   // ------------------------------------------------------------
   // Scoreboard and protocol checks
   // ------------------------------------------------------------
   always @(posedge clk) begin
      if (!rst) begin
         assert (!mem_addr_rd_en || mem_addr_valid)
            else note_problem("memory popped an empty address FIFO");
         assert (!mem_data_wr_en || !mem_data_full)
            else note_problem("memory pushed into a full data FIFO");
         assert (started || !mem_addr_valid)
            else note_problem("address issued before any start");
         assert (active || pix_stall)
            else note_problem("pix_stall low with no frame running");

         // Addresses of an older frame are stale but still answered
         if (mem_addr_valid && mem_addr_rd_en) begin
            popped = mem_addr;
            if (active && popped[24:19] == cur_fsel) begin
               assert (popped == addr_of(cur_fsel, exp_n))
                  else flag_mismatch($sformatf("address %h, expected %h",
                                               popped, addr_of(cur_fsel, exp_n)));
               exp_n++;
            end else begin
               assert (popped[30:25] == '0 && popped[1:0] == '0 && stale_fsel[popped[24:19]])
                  else flag_mismatch($sformatf("address %h belongs to no issued frame",
                                               popped));
               // Only an address already queued at the abort may drain out
               if (!active) begin
                  assert (late_room > 0)
                     else note_problem("address pushed after the abort");
                  late_room--;
               end
            end
         end

         if (!start && !abort && !pix_stall && !pix_hold && active) begin
            exp_word = word_of(addr_of(cur_fsel, pix_idx / 8), 3'(pix_idx % 8));
            assert (pix_data == exp_word)
               else flag_mismatch($sformatf("word %0d of frame %h: got %h, expected %h",
                                            pix_idx, cur_fsel, pix_data, exp_word));
            pix_idx++;
         end

         if (start) begin
            if (active) begin
               stale_fsel[cur_fsel] = 1'b1;
            end
            cur_fsel = start_code[27:22];
            active   = 1'b1;
            started  = 1'b1;
            exp_n    = 0;
            pix_idx  = 0;
         end else if (abort) begin
            if (active) begin
               stale_fsel[cur_fsel] = 1'b1;
            end
            // A frame waits on at most one request in the address FIFO
            late_room = (mem_addr_valid && !mem_addr_rd_en) ? 1 : 0;
            active    = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   task automatic start_frame(input logic [5:0] fs);
      @(posedge clk);
      start      <= 1'b1;
      start_code <= {4'ha, fs, 22'h2d_a3c5};
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
   endtask

   task automatic await_words(input int n);
      while (pix_idx < n) begin
         @(posedge clk);
      end
   endtask

   task automatic wait_in_flight();
      while (pend_addr.size() == 0) begin
         @(posedge clk);
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         n_pass++;
         $display("test %s: ok", name);
      end else begin
         n_fail++;
         $display("test %s: %0d errors", name, errors - errs_before);
      end
   endtask

   initial begin
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      mark = errors;
      repeat (20) @(posedge clk);
      finish_test("reset state", mark);

      mark = errors;
      start_frame(6'h05);
      await_words(REQS_SEQ * 8);
      finish_test("address sequence and pixel order", mark);

      mark = errors;
      rand_on <= 1'b1;
      start_frame(6'h2a);
      await_words(REQS_BP * 8);
      finish_test("back-pressure", mark);

      // Restart with beats in flight and then a burst that fills the address FIFO
      mark = errors;
      start_frame(6'h13);
      await_words(12 * 8);
      wait_in_flight();
      start_frame(6'h3c);
      await_words(40 * 8);
      pop_en <= 1'b0;
      for (int i = 0; i < 5; i++) begin
         start_frame(6'h21 + 6'(i));
         repeat (6) @(posedge clk);
      end
      pop_en <= 1'b1;
      await_words(20 * 8);
      finish_test("restart", mark);

      mark = errors;
      start_frame(6'h0e);
      await_words(REQS_ABORT * 8);
      wait_in_flight();
      @(posedge clk);
      abort <= 1'b1;
      @(posedge clk);
      abort <= 1'b0;
      while (pend_addr.size() != 0 || mem_addr_valid || mem_data_wr_en) begin
         @(posedge clk);
      end
      repeat (50) begin
         @(posedge clk);
         assert (!mem_addr_valid) else note_problem("address issued after abort drained");
      end
      finish_test("abort", mark);

      $display("tests passed %0d, failed %0d, failed checks %0d", n_pass, n_fail, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
gp_mem_pkg.sv
gp_frame_pkg.sv
sync_fifo.sv
pixel_prefetch.sv
gp_fetch_top.sv
tb_gp_fetch.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_gp_fetch
RTL_TOP   ?= gp_fetch_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= >>> PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out=$$(./$(SIM_BIN)); echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
